//--- filelist.f
logic/rv32i_pkg.sv
logic/control_unit.sv
logic/rv32i_reg_file.sv
logic/alu.sv
logic/fetch_stage.sv
logic/data_align.sv
logic/rv32i_core.sv
test/tb_clock_gen.sv
test/rv32i_core_asserts.sv
test/rv32i_core_tb.sv

//--- logic/alu.sv
`timescale 1ns/1ps

module alu import rv32i_pkg::*; (
  input  word_t   a_i,
  input  word_t   b_i,
  input  alu_op_t op_i,
  output word_t   result_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b_i[4:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_AND:  result_o = a_i & b_i;
      ALU_OR:   result_o = a_i | b_i;
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = word_t'($signed(a_i) >>> shamt);
      // Compares give 0 or 1
      ALU_SLT:  result_o = {31'b0, lt_signed};
      ALU_SLTU: result_o = {31'b0, lt_unsigned};
      default:  result_o = '0;
    endcase
  end

endmodule

//--- logic/control_unit.sv
`timescale 1ns/1ps

module control_unit import rv32i_pkg::*; (
  input  word_t         instr_i,
  input  logic [1:0]    byte_offset_i,
  output logic [4:0]    rs1_o,
  output logic [4:0]    rs2_o,
  output logic [4:0]    rd_o,
  output logic          reg_wen_o,
  output word_t         imm_i_o,
  output word_t         imm_s_o,
  output word_t         imm_sb_o,
  output word_t         imm_u_o,
  output word_t         imm_uj_o,
  output logic          shamt_sel_o,
  output logic [1:0]    alu_a_sel_o,
  output logic [1:0]    alu_b_sel_o,
  output logic [1:0]    w_sel_o,
  output alu_op_t       alu_op_o,
  output logic          branch_o,
  output logic          jump_o,
  output logic          j_sel_o,
  output branch_t       branch_type_o,
  output load_t         load_type_o,
  output logic [3:0]    byte_en_o,
  output logic          dren_o,
  output logic          dwen_o
);

  instr_t  instr;
  opcode_t opcode;
  logic    alt;

  assign instr  = instr_i;
  assign opcode = opcode_t'(instr.rtype.opcode);
  // Instruction bit 30 selects SUB and SRA
  assign alt    = instr.rtype.funct7[5];

  assign rs1_o = instr.rtype.rs1;
  assign rs2_o = instr.rtype.rs2;
  assign rd_o  = instr.rtype.rd;

  // Sign-extended immediates
  assign imm_i_o  = {{20{instr.itype.imm11_00[11]}}, instr.itype.imm11_00};
  assign imm_s_o  = {{20{instr.stype.imm11_05[6]}}, instr.stype.imm11_05,
                     instr.stype.imm04_00};
  assign imm_sb_o = {{19{instr.sbtype.imm12}}, instr.sbtype.imm12, instr.sbtype.imm11,
                     instr.sbtype.imm10_05, instr.sbtype.imm04_01, 1'b0};
  assign imm_u_o  = {instr.utype.imm31_12, 12'b0};
  assign imm_uj_o = {{11{instr.ujtype.imm20}}, instr.ujtype.imm20, instr.ujtype.imm19_12,
                     instr.ujtype.imm11, instr.ujtype.imm10_01, 1'b0};

  assign shamt_sel_o = (opcode == IMMED) &&
                       (instr.itype.funct3 == SLL || instr.itype.funct3 == SR);

  assign load_type_o   = load_t'(instr.itype.funct3);
  assign branch_type_o = branch_t'(instr.sbtype.funct3);

  // Lanes from access size and address offset
  always_comb begin
    case (load_type_o)
      LB, LBU: byte_en_o = 4'b0001 << byte_offset_i;
      LH, LHU: begin
        case (byte_offset_i)
          2'b00:   byte_en_o = 4'b0011;
          2'b10:   byte_en_o = 4'b1100;
          default: byte_en_o = 4'b0000;
        endcase
      end
      LW:      byte_en_o = 4'b1111;
      default: byte_en_o = 4'b0000;
    endcase
  end

  assign dwen_o = (opcode == STORE);
  assign dren_o = (opcode == LOAD);

  assign branch_o = (opcode == BRANCH);
  assign jump_o   = (opcode == JAL) || (opcode == JALR);
  assign j_sel_o  = (opcode == JAL);

  always_comb begin
    case (opcode)
      AUIPC:   alu_a_sel_o = ALU_A_IMM_U;
      default: alu_a_sel_o = ALU_A_RS1;
    endcase
  end

  always_comb begin
    case (opcode)
      REGREG:  alu_b_sel_o = ALU_B_RS2;
      STORE:   alu_b_sel_o = ALU_B_IMM_S;
      AUIPC:   alu_b_sel_o = ALU_B_PC;
      default: alu_b_sel_o = ALU_B_IMM_I;
    endcase
  end

  always_comb begin
    case (opcode)
      JAL, JALR: w_sel_o = W_SEL_LINK;
      LUI:       w_sel_o = W_SEL_IMM_U;
      IMMED, AUIPC, REGREG: w_sel_o = W_SEL_ALU;
      default:   w_sel_o = W_SEL_LOAD;
    endcase
  end

  // FENCE and SYSTEM fall to the default and write nothing
  always_comb begin
    case (opcode)
      IMMED, LUI, AUIPC, REGREG, JAL, JALR, LOAD: reg_wen_o = 1'b1;
      default:                                   reg_wen_o = 1'b0;
    endcase
  end

  // Loads, stores, AUIPC and JALR all add
  always_comb begin
    alu_op_o = ALU_ADD;
    if (opcode == REGREG || opcode == IMMED) begin
      case (instr.rtype.funct3)
        ADDSUB:  alu_op_o = (opcode == REGREG && alt) ? ALU_SUB : ALU_ADD;
        SLL:     alu_op_o = ALU_SLL;
        SLT:     alu_op_o = ALU_SLT;
        SLTU:    alu_op_o = ALU_SLTU;
        XOR:     alu_op_o = ALU_XOR;
        SR:      alu_op_o = alt ? ALU_SRA : ALU_SRL;
        OR:      alu_op_o = ALU_OR;
        AND:     alu_op_o = ALU_AND;
        default: alu_op_o = ALU_ADD;
      endcase
    end
  end

endmodule

//--- logic/data_align.sv
`timescale 1ns/1ps

module data_align import rv32i_pkg::*; (
  input  logic [3:0] byte_en_i,
  input  load_t      load_type_i,
  input  word_t      store_data_i,
  input  word_t      load_word_i,
  output word_t      store_word_o,
  output word_t      load_data_o
);

  word_t lanes;

  // Replicate so every enabled lane sees the data
  always_comb begin
    case (load_type_i)
      LB, LBU: store_word_o = {4{store_data_i[7:0]}};
      LH, LHU: store_word_o = {2{store_data_i[15:0]}};
      default: store_word_o = store_data_i;
    endcase
  end

  // Move enabled lanes down to bit 0
  always_comb begin
    case (byte_en_i)
      4'b0010: lanes = load_word_i >> 8;
      4'b0100: lanes = load_word_i >> 16;
      4'b1000: lanes = load_word_i >> 24;
      4'b1100: lanes = load_word_i >> 16;
      default: lanes = load_word_i;
    endcase
  end

  always_comb begin
    case (load_type_i)
      LB:      load_data_o = {{24{lanes[7]}}, lanes[7:0]};
      LBU:     load_data_o = {24'b0, lanes[7:0]};
      LH:      load_data_o = {{16{lanes[15]}}, lanes[15:0]};
      LHU:     load_data_o = {16'b0, lanes[15:0]};
      default: load_data_o = lanes;
    endcase
  end

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import rv32i_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic    CLK,
  input  logic    rst_n_i,
  input  logic    branch_i,
  input  logic    jump_i,
  input  logic    j_sel_i,
  input  branch_t branch_type_i,
  input  word_t   rs1_data_i,
  input  word_t   rs2_data_i,
  input  word_t   imm_sb_i,
  input  word_t   imm_uj_i,
  input  word_t   jalr_target_i,
  output word_t   pc_o,
  output word_t   pc_plus4_o,
  output logic    run_o
);

  word_t pc;
  word_t next_pc;
  logic  run;
  logic  taken;

  assign pc_plus4_o = pc + 32'd4;

  always_comb begin
    case (branch_type_i)
      BEQ:     taken = rs1_data_i == rs2_data_i;
      BNE:     taken = rs1_data_i != rs2_data_i;
      BLT:     taken = $signed(rs1_data_i) < $signed(rs2_data_i);
      BGE:     taken = $signed(rs1_data_i) >= $signed(rs2_data_i);
      BLTU:    taken = rs1_data_i < rs2_data_i;
      BGEU:    taken = rs1_data_i >= rs2_data_i;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (jump_i && j_sel_i) begin
      next_pc = pc + imm_uj_i;
    end else if (jump_i) begin
      // JALR clears the low bit
      next_pc = {jalr_target_i[31:1], 1'b0};
    end else if (branch_i && taken) begin
      next_pc = pc + imm_sb_i;
    end else begin
      next_pc = pc_plus4_o;
    end
  end

  // Run goes high one edge after reset release, PC holds until then
  always_ff @(posedge CLK, negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc  <= RESET_PC;
      run <= 1'b0;
    end else begin
      run <= 1'b1;
      if (run) begin
        pc <= next_pc;
      end
    end
  end

  assign pc_o  = pc;
  assign run_o = run;

endmodule

//--- logic/rv32i_core.sv
`timescale 1ns/1ps

module rv32i_core import rv32i_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic       CLK,
  input  logic       rst_n_i,
  output word_t      imem_addr_o,
  input  word_t      imem_rdata_i,
  output word_t      dmem_addr_o,
  output word_t      dmem_wdata_o,
  output logic [3:0] dmem_byte_en_o,
  output logic       dmem_ren_o,
  output logic       dmem_wen_o,
  input  word_t      dmem_rdata_i
);

  word_t      pc, pc_plus4;
  logic       run;
  logic [4:0] rs1, rs2, rd;
  logic       cu_reg_wen, reg_wen;
  word_t      imm_i, imm_s, imm_sb, imm_u, imm_uj;
  logic       shamt_sel;
  logic [1:0] alu_a_sel, alu_b_sel, w_sel;
  alu_op_t    alu_op;
  logic       branch, jump, j_sel;
  branch_t    branch_type;
  load_t      load_type;
  logic [3:0] byte_en;
  logic       dren, dwen;
  word_t      rs1_data, rs2_data;
  word_t      alu_a, alu_b, alu_result;
  word_t      load_data, wdata;

  control_unit u_control (
    .instr_i(imem_rdata_i), .byte_offset_i(alu_result[1:0]),
    .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .reg_wen_o(cu_reg_wen),
    .imm_i_o(imm_i), .imm_s_o(imm_s), .imm_sb_o(imm_sb), .imm_u_o(imm_u),
    .imm_uj_o(imm_uj), .shamt_sel_o(shamt_sel),
    .alu_a_sel_o(alu_a_sel), .alu_b_sel_o(alu_b_sel), .w_sel_o(w_sel),
    .alu_op_o(alu_op), .branch_o(branch), .jump_o(jump), .j_sel_o(j_sel),
    .branch_type_o(branch_type), .load_type_o(load_type), .byte_en_o(byte_en),
    .dren_o(dren), .dwen_o(dwen)
  );

  // Nothing writes state until the first cycle after reset
  assign reg_wen    = cu_reg_wen & run;
  assign dmem_ren_o = dren & run;
  assign dmem_wen_o = dwen & run;

  rv32i_reg_file u_regs (
    .CLK(CLK), .rst_n_i(rst_n_i), .wen_i(reg_wen), .rd_i(rd),
    .rs1_i(rs1), .rs2_i(rs2), .wdata_i(wdata),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
  );

  always_comb begin
    case (alu_a_sel)
      ALU_A_IMM_U: alu_a = imm_u;
      default:     alu_a = rs1_data;
    endcase
  end

  // Shift immediates use only the shamt field
  always_comb begin
    case (alu_b_sel)
      ALU_B_RS2:   alu_b = rs2_data;
      ALU_B_IMM_S: alu_b = imm_s;
      ALU_B_PC:    alu_b = pc;
      default:     alu_b = shamt_sel ? {27'b0, rs2} : imm_i;
    endcase
  end

  alu u_alu (.a_i(alu_a), .b_i(alu_b), .op_i(alu_op), .result_o(alu_result));

  fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
    .CLK(CLK), .rst_n_i(rst_n_i), .branch_i(branch), .jump_i(jump), .j_sel_i(j_sel),
    .branch_type_i(branch_type), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .imm_sb_i(imm_sb), .imm_uj_i(imm_uj), .jalr_target_i(alu_result),
    .pc_o(pc), .pc_plus4_o(pc_plus4), .run_o(run)
  );

  data_align u_align (
    .byte_en_i(byte_en), .load_type_i(load_type), .store_data_i(rs2_data),
    .load_word_i(dmem_rdata_i), .store_word_o(dmem_wdata_o), .load_data_o(load_data)
  );

  always_comb begin
    case (w_sel)
      W_SEL_LOAD:  wdata = load_data;
      W_SEL_LINK:  wdata = pc_plus4;
      W_SEL_IMM_U: wdata = imm_u;
      default:     wdata = alu_result;
    endcase
  end

  assign imem_addr_o    = pc;
  assign dmem_addr_o    = alu_result;
  assign dmem_byte_en_o = byte_en;

endmodule

//--- logic/rv32i_pkg.sv
package rv32i_pkg;

  typedef logic [31:0] word_t;

  // Major opcodes
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    IMMED  = 7'b0010011,
    REGREG = 7'b0110011
  } opcode_t;

  // Same funct3 positions for loads and stores
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  // funct3 of REGREG and IMMED
  localparam logic [2:0] ADDSUB = 3'b000;
  localparam logic [2:0] SLL    = 3'b001;
  localparam logic [2:0] SLT    = 3'b010;
  localparam logic [2:0] SLTU   = 3'b011;
  localparam logic [2:0] XOR    = 3'b100;
  localparam logic [2:0] SR     = 3'b101;
  localparam logic [2:0] OR     = 3'b110;
  localparam logic [2:0] AND    = 3'b111;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_t;

  // ALU port A sources
  localparam logic [1:0] ALU_A_RS1   = 2'd0;
  localparam logic [1:0] ALU_A_IMM_U = 2'd2;

  // ALU port B sources
  localparam logic [1:0] ALU_B_IMM_I = 2'd0;
  localparam logic [1:0] ALU_B_RS2   = 2'd1;
  localparam logic [1:0] ALU_B_IMM_S = 2'd2;
  localparam logic [1:0] ALU_B_PC    = 2'd3;

  // Write-back sources
  localparam logic [1:0] W_SEL_LOAD  = 2'd0;
  localparam logic [1:0] W_SEL_LINK  = 2'd1;
  localparam logic [1:0] W_SEL_IMM_U = 2'd2;
  localparam logic [1:0] W_SEL_ALU   = 2'd3;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rtype_t;

  typedef struct packed {
    logic [11:0] imm11_00;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } itype_t;

  typedef struct packed {
    logic [6:0] imm11_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm04_00;
    logic [6:0] opcode;
  } stype_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm04_01;
    logic       imm11;
    logic [6:0] opcode;
  } sbtype_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } utype_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_01;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } ujtype_t;

  // All format views of one fetched word
  typedef union packed {
    rtype_t  rtype;
    itype_t  itype;
    stype_t  stype;
    sbtype_t sbtype;
    utype_t  utype;
    ujtype_t ujtype;
  } instr_t;

endpackage

//--- logic/rv32i_reg_file.sv
`timescale 1ns/1ps

module rv32i_reg_file import rv32i_pkg::*; (
  input  logic       CLK,
  input  logic       rst_n_i,
  input  logic       wen_i,
  input  logic [4:0] rd_i,
  input  logic [4:0] rs1_i,
  input  logic [4:0] rs2_i,
  input  word_t      wdata_i,
  output word_t      rs1_data_o,
  output word_t      rs2_data_o
);

  word_t regs [32];

  always_ff @(posedge CLK, negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && rd_i != 5'd0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // x0 is never written so it reads zero
  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module rv32i_core_tb -f filelist.f -o sim_rv32i_core

./obj_dir/sim_rv32i_core 2>&1 | tee sim.log

if grep -q "test failed" sim.log; then
  exit 1
fi
exit 0

//--- test/rv32i_core_asserts.sv
`timescale 1ns/1ps

module rv32i_core_asserts (
  input logic        CLK,
  input logic        rst_n_i,
  input logic [31:0] imem_addr_o,
  input logic [3:0]  dmem_byte_en_o,
  input logic        dmem_ren_o,
  input logic        dmem_wen_o
);

  no_read_and_write: assert property (@(posedge CLK) disable iff (!rst_n_i)
    !(dmem_wen_o && dmem_ren_o))
    else $error("Data memory read and write enables are both high");

  write_has_lanes: assert property (@(posedge CLK) disable iff (!rst_n_i)
    dmem_wen_o |-> dmem_byte_en_o != 4'b0000)
    else $error("Data memory write without byte enables");

  pc_aligned: assert property (@(posedge CLK) disable iff (!rst_n_i)
    imem_addr_o[1:0] == 2'b00)
    else $error("Instruction address is not word aligned");

  // No disable here, this one is about reset itself
  quiet_in_reset: assert property (@(posedge CLK)
    !rst_n_i |-> !dmem_wen_o && !dmem_ren_o)
    else $error("Memory enable is high during reset");

endmodule

bind rv32i_core rv32i_core_asserts u_asserts (.*);

//--- test/rv32i_core_tb.sv
`timescale 1ns/1ps

module rv32i_core_tb;

  localparam int          NUM_TESTS   = 6;
  localparam int          WATCHDOG_NS = NUM_TESTS * 80 * 8;
  localparam logic [31:0] MARKER      = 32'h0bad_beef;

  logic        clk;
  logic        rst_n;
  logic        start_req;
  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [31:0] dmem_rdata;
  logic [3:0]  dmem_byte_en;
  logic        dmem_ren;
  logic        dmem_wen;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  int          pc_idx;
  int          err_cnt;
  int          rd_cnt;
  int          exp_slot [$];
  logic [31:0] exp_val [$];
  logic [31:0] log_addr [$];
  logic [31:0] log_data [$];
  logic [3:0]  log_be [$];

  tb_clock_gen u_clk (.start_i(start_req), .clk_o(clk), .rst_n_o(rst_n));

  rv32i_core #(.RESET_PC(32'h0)) uut (
    .CLK(clk), .rst_n_i(rst_n),
    .imem_addr_o(imem_addr), .imem_rdata_i(imem_rdata),
    .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata), .dmem_byte_en_o(dmem_byte_en),
    .dmem_ren_o(dmem_ren), .dmem_wen_o(dmem_wen), .dmem_rdata_i(dmem_rdata)
  );

  assign imem_rdata = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  // Byte-enabled write at the edge that ends the store cycle
  always @(posedge clk) begin
    if (dmem_wen) begin
      for (int i = 0; i < 4; i++) begin
        if (dmem_byte_en[i]) begin
          dmem[dmem_addr[9:2]][8*i +: 8] = dmem_wdata[8*i +: 8];
        end
      end
      log_addr.push_back(dmem_addr);
      log_data.push_back(dmem_wdata);
      log_be.push_back(dmem_byte_en);
    end
  end

  // Cycles with the data read enable high
  always @(posedge clk) begin
    if (dmem_ren) begin
      rd_cnt++;
    end
  end

  // Instruction encoders from the RV32I formats
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] fill_value(int i);
    return (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
  endfunction

  function automatic logic [31:0] lane_mask(logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] x,
                                          logic [31:0] y);
    logic signed [31:0] sx;
    logic signed [31:0] sy;
    sx = x;
    sy = y;
    case (f3)
      3'd0: return alt ? x - y : x + y;
      3'd1: return x << y[4:0];
      3'd2: return (sx < sy) ? 32'd1 : 32'd0;
      3'd3: return (x < y) ? 32'd1 : 32'd0;
      3'd4: return x ^ y;
      3'd5: begin
        if (alt) begin
          return sx >>> y[4:0];
        end
        return x >> y[4:0];
      end
      3'd6: return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_ref(logic [2:0] f3, logic [31:0] x, logic [31:0] y);
    logic signed [31:0] sx;
    logic signed [31:0] sy;
    sx = x;
    sy = y;
    case (f3)
      3'd0: return x == y;
      3'd1: return x != y;
      3'd4: return sx < sy;
      3'd5: return sx >= sy;
      3'd6: return x < y;
      default: return x >= y;
    endcase
  endfunction

  task automatic emit(input logic [31:0] w);
    imem[pc_idx] = w;
    pc_idx++;
  endtask

  // LUI plus ADDI, upper part rounded for the signed low half
  task automatic load_imm(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    emit(enc_u(hi[31:12], rd, 7'h37));
    emit(enc_i(v[11:0], rd, 3'b000, rd, 7'h13));
  endtask

  task automatic store_slot(input logic [4:0] rs, input int slot);
    emit(enc_s(12'(slot * 4), rs, 5'd0, 3'b010));
  endtask

  task automatic push_expect(input int slot, input logic [31:0] v);
    exp_slot.push_back(slot);
    exp_val.push_back(v);
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("Error %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_log_size(input string what, input int exp);
    assert (log_be.size() == exp) else begin
      err_cnt++;
      $display("Error %0t ns: %s wrote %0d times, expected %0d", $time, what,
               log_be.size(), exp);
    end
  endtask

  // Hold the core in reset while the memories are refilled
  task automatic begin_program();
    @(posedge clk);
    #1;
    start_req = 1'b1;
    @(posedge clk);
    #1;
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'h0000_006f;
      dmem[i] = fill_value(i);
    end
    pc_idx = 0;
    exp_slot.delete();
    exp_val.delete();
  endtask

  task automatic run_program();
    emit(enc_j(21'd0, 5'd0));
    log_addr.delete();
    log_data.delete();
    log_be.delete();
    rd_cnt = 0;
    start_req = 1'b0;
    wait (rst_n);
    repeat (64) @(posedge clk);
    #1;
  endtask

  task automatic check_expected(input string name);
    for (int k = 0; k < exp_slot.size(); k++) begin
      check_value($sformatf("%s word %0d", name, exp_slot[k]), dmem[exp_slot[k]], exp_val[k]);
    end
  endtask

  task automatic test_alu();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] y;
    logic [11:0] imm;
    logic [11:0] field;
    int          slot;
    begin_program();
    a = $urandom();
    b = $urandom();
    imm = 12'($urandom());
    slot = 0;
    load_imm(5'd1, a);
    load_imm(5'd2, b);
    for (int f = 0; f < 8; f++) begin
      for (int alt = 0; alt < 2; alt++) begin
        if (alt == 1 && f != 0 && f != 5) begin
          continue;
        end
        emit(enc_r((alt == 1) ? 7'h20 : 7'h00, 5'd2, 5'd1, 3'(f), 5'd3, 7'h33));
        store_slot(5'd3, slot);
        push_expect(slot, alu_ref(3'(f), 1'(alt), a, b));
        slot++;
        // No SUBI in the ISA
        if (f == 0 && alt == 1) begin
          continue;
        end
        if (f == 1 || f == 5) begin
          field = {(alt == 1) ? 7'h20 : 7'h00, b[4:0]};
          y = {27'b0, b[4:0]};
        end else begin
          field = imm;
          y = {{20{imm[11]}}, imm};
        end
        emit(enc_i(field, 5'd1, 3'(f), 5'd3, 7'h13));
        store_slot(5'd3, slot);
        push_expect(slot, alu_ref(3'(f), 1'(alt), a, y));
        slot++;
      end
    end
    run_program();
    check_expected("ALU");
    check_value("ALU read cycles", 32'(rd_cnt), 32'd0);
  endtask

  task automatic test_upper();
    logic [19:0] u;
    int          p;
    begin_program();
    u = 20'($urandom());
    emit(enc_u(u, 5'd4, 7'h37));
    store_slot(5'd4, 0);
    push_expect(0, {u, 12'b0});
    p = pc_idx;
    emit(enc_u(u, 5'd5, 7'h17));
    store_slot(5'd5, 1);
    push_expect(1, {u, 12'b0} + 32'(p * 4));
    run_program();
    check_expected("LUI/AUIPC");
  endtask

  task automatic test_store_lanes();
    logic [31:0] v;
    logic [31:0] w;
    logic [31:0] e_addr [6];
    logic [31:0] e_data [6];
    logic [3:0]  e_be [6];
    int          word;
    begin_program();
    v = $urandom();
    load_imm(5'd6, v);
    for (int off = 0; off < 4; off++) begin
      word = 40 + off;
      e_addr[off] = 32'(word * 4 + off);
      e_be[off] = 4'b0001 << off;
      e_data[off] = {24'b0, v[7:0]} << (8 * off);
      emit(enc_s(12'(word * 4 + off), 5'd6, 5'd0, 3'b000));
      w = fill_value(word);
      w[8*off +: 8] = v[7:0];
      push_expect(word, w);
    end
    for (int h = 0; h < 2; h++) begin
      word = 44 + h;
      e_addr[4+h] = 32'(word * 4 + 2 * h);
      e_be[4+h] = (h == 1) ? 4'b1100 : 4'b0011;
      e_data[4+h] = {16'b0, v[15:0]} << (16 * h);
      emit(enc_s(12'(word * 4 + 2 * h), 5'd6, 5'd0, 3'b001));
      w = fill_value(word);
      w[16*h +: 16] = v[15:0];
      push_expect(word, w);
    end
    run_program();
    check_expected("sub-word store");
    check_log_size("sub-word store", 6);
    for (int k = 0; k < log_be.size() && k < 6; k++) begin
      check_value("store address", log_addr[k], e_addr[k]);
      check_value("store byte enables", {28'b0, log_be[k]}, {28'b0, e_be[k]});
      check_value("store lanes", log_data[k] & lane_mask(log_be[k]), e_data[k]);
    end
  endtask

  task automatic load_and_store(input logic [2:0] f3, input int addr, inout int slot,
                                input logic [31:0] exp);
    emit(enc_i(12'(addr), 5'd0, f3, 5'd7, 7'h03));
    store_slot(5'd7, slot);
    push_expect(slot, exp);
    slot++;
  endtask

  task automatic test_loads();
    logic [31:0] w;
    logic [7:0]  bt;
    logic [15:0] hw;
    int          slot;
    begin_program();
    // Top bit of every byte set so sign extension shows
    w = $urandom() | 32'h8080_8080;
    dmem[50] = w;
    slot = 0;
    for (int off = 0; off < 4; off++) begin
      bt = w[8*off +: 8];
      load_and_store(3'b000, 200 + off, slot, {{24{bt[7]}}, bt});
      load_and_store(3'b100, 200 + off, slot, {24'b0, bt});
      if (off % 2 == 0) begin
        hw = w[8*off +: 16];
        load_and_store(3'b001, 200 + off, slot, {{16{hw[15]}}, hw});
        load_and_store(3'b101, 200 + off, slot, {16'b0, hw});
      end
    end
    load_and_store(3'b010, 200, slot, w);
    run_program();
    check_expected("load");
    // One read cycle per load
    check_value("load read cycles", 32'(rd_cnt), 32'(slot));
  endtask

  task automatic test_branches();
    logic [2:0]  bt [6];
    logic [31:0] rv [3];
    int          ra [3];
    int          rb [3];
    int          slot;
    int          p;
    bt = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    ra = '{1, 2, 1};
    rb = '{2, 1, 1};
    rv = '{32'h0, 32'hffff_fffb, 32'd7};
    begin_program();
    slot = 0;
    load_imm(5'd1, rv[1]);
    load_imm(5'd2, rv[2]);
    load_imm(5'd10, MARKER);
    for (int t = 0; t < 6; t++) begin
      for (int q = 0; q < 3; q++) begin
        // Taken skips the marker store
        emit(enc_b(13'd8, 5'(rb[q]), 5'(ra[q]), bt[t]));
        store_slot(5'd10, slot);
        if (branch_ref(bt[t], rv[ra[q]], rv[rb[q]])) begin
          push_expect(slot, fill_value(slot));
        end else begin
          push_expect(slot, MARKER);
        end
        slot++;
      end
    end
    p = pc_idx;
    emit(enc_j(21'd8, 5'd12));
    store_slot(5'd10, slot);
    store_slot(5'd12, slot + 1);
    push_expect(slot, fill_value(slot));
    push_expect(slot + 1, 32'(p * 4 + 4));
    slot += 2;
    // JALR target plus one, bit 0 dropped by the jump
    p = pc_idx;
    load_imm(5'd13, 32'((p + 4) * 4));
    emit(enc_i(12'd1, 5'd13, 3'b000, 5'd14, 7'h67));
    store_slot(5'd10, slot);
    store_slot(5'd14, slot + 1);
    push_expect(slot, fill_value(slot));
    push_expect(slot + 1, 32'((p + 2) * 4 + 4));
    run_program();
    check_expected("branch/jump");
  endtask

  task automatic test_x0();
    begin_program();
    emit(enc_i(12'h123, 5'd0, 3'b000, 5'd0, 7'h13));
    emit(enc_u(20'habcde, 5'd0, 7'h37));
    load_imm(5'd15, MARKER);
    emit(enc_r(7'h00, 5'd15, 5'd0, 3'b000, 5'd16, 7'h33));
    store_slot(5'd0, 0);
    store_slot(5'd16, 1);
    push_expect(0, 32'h0);
    push_expect(1, MARKER);
    run_program();
    check_expected("x0");
    check_log_size("x0", 2);
    if (log_be.size() > 0) begin
      check_value("x0 store enables", {28'b0, log_be[0]}, 32'hf);
      check_value("x0 store data", log_data[0], 32'h0);
    end
  endtask

  initial begin
    void'($urandom(32'h63d2_eb2e));
    start_req = 1'b1;
    err_cnt = 0;
    rd_cnt = 0;
    pc_idx = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'h0000_006f;
      dmem[i] = fill_value(i);
    end
    test_alu();
    test_upper();
    test_store_lanes();
    test_loads();
    test_branches();
    test_x0();
    $display("Errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog, about 80 cycles per test
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  input  logic start_i,
  output logic clk_o,
  output logic rst_n_o
);

  int unsigned cycles = 0;

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset stays low for 8 edges after the start request drops
  always @(posedge clk_o) begin
    if (start_i) begin
      cycles <= 0;
    end else if (cycles < 8) begin
      cycles <= cycles + 1;
    end
  end

  // Reset follows the count 1 ns after each edge
  initial begin
    rst_n_o = 1'b0;
    forever begin
      @(posedge clk_o);
      #1;
      rst_n_o = (cycles >= 8);
    end
  end

endmodule
